// File: compile.f
uart_frame_pkg.sv
uart_cmd_pkg.sv
uart_baud_gen.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_fsm.sv
uart_cmd_bridge.sv
tb_uart_cmd_bridge.sv

// File: Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - uart_frame_pkg.sv
  - uart_cmd_pkg.sv
  - uart_baud_gen.sv
  - uart_tx_frame.sv
  - uart_rx_frame.sv
  - uart_cmd_fsm.sv
  - uart_cmd_bridge.sv
  - target: test
    files:
      - tb_uart_cmd_bridge.sv

// File: tb_uart_cmd_bridge.sv
`default_nettype none
`timescale 1ns/10ps

module tb_uart_cmd_bridge
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
();

  localparam int CLKS_PER_BIT      = 16;
  localparam int GAP_BITS          = 16;
  localparam int RESP_TIMEOUT_BITS = 64;
  localparam int ROW_LIMIT    = (22 + GAP_BITS + RESP_TIMEOUT_BITS) * CLKS_PER_BIT * 2;
  localparam int WRITE_CYCLES = (22 + GAP_BITS) * CLKS_PER_BIT + 2;

  typedef enum logic [1:0] {
    MODE_NORMAL,
    MODE_BAD_PARITY,
    MODE_BAD_STOP,
    MODE_SILENT
  } reply_mode_e;

  typedef struct packed {
    cmd_word_t            cmd;
    reply_mode_e          mode;
    logic                 poke;             // Extra cmd_vld while busy.
    logic [DATA_BITS-1:0] exp_data;
    logic                 exp_err;
  } test_row_t;

  logic       clk;
  logic       rst_n;
  cmd_word_t  cmd;
  logic       cmd_vld;
  logic       rx;
  logic       tx;
  logic       cmd_rdy;
  logic       read_vld;
  read_resp_t read_resp;

  test_row_t            rows[$];
  logic [DATA_BITS-1:0] dev_mem [128];     // Remote device registers.
  logic [DATA_BITS-1:0] exp_mem [128];
  logic [DATA_BITS-1:0] frame_q[$];
  reply_mode_e          reply_mode;
  integer               seed;
  int                   frames_seen  = 0;
  int                   errors       = 0;
  int                   failed_tests = 0;
  int                   cycles       = 0;
  int                   cycle_limit  = 0;

  uart_cmd_bridge #(
    .CLKS_PER_BIT      (CLKS_PER_BIT),
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) uart_cmd_bridge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_resp (read_resp)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("run stopped at cycle limit %0d, sequencer in state %s",
               cycle_limit, uart_cmd_bridge_i.uart_cmd_fsm_i.state.name());
      $display("Errors found");
      $finish;
    end
  end

  task automatic check(input logic ok, input string msg);
    assert (ok)
    else
    begin
      $display("error %0t: %s", $time, msg);
      errors++;
    end
  endtask

  function automatic cmd_word_t make_cmd(input cmd_op_e op, input logic [6:0] addr,
                                         input logic [DATA_BITS-1:0] payload);
    cmd_word_t c;
    if (op == OP_WRITE)
    begin
      c.wr.op   = op;
      c.wr.addr = addr;
      c.wr.data = payload;
    end
    else
    begin
      c.rd.op   = op;
      c.rd.addr = addr;
      c.rd.rsvd = 8'h5a;                    // Not sent on the line.
    end
    return c;
  endfunction

  // Expected values follow the device copy in row order.
  task automatic add_row(input cmd_op_e op, input logic [6:0] addr,
                         input logic [DATA_BITS-1:0] payload, input reply_mode_e mode,
                         input logic poke);
    test_row_t r;
    r.cmd      = make_cmd(op, addr, payload);
    r.mode     = mode;
    r.poke     = poke;
    r.exp_err  = (op == OP_READ) && (mode != MODE_NORMAL);
    r.exp_data = (mode == MODE_SILENT) ? '0 : exp_mem[addr];
    if (op == OP_WRITE)
      exp_mem[addr] = payload;
    rows.push_back(r);
  endtask

  // ----------------------------------------
  // Remote device line model
  // ----------------------------------------
  task automatic take_frame(output logic [DATA_BITS-1:0] data);
    logic par;
    @(negedge tx);
    repeat (CLKS_PER_BIT / 2) @(posedge clk);
    check(tx == 1'b0, "start bit on tx did not last to mid-bit");
    frames_seen++;
    for (int i = 0; i < DATA_BITS; i++)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data[i] = tx;                         // LSB first.
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    par = tx;
    check(par == ^data, $sformatf("odd parity on tx frame %h", data));
    repeat (CLKS_PER_BIT) @(posedge clk);
    check(tx == 1'b1, $sformatf("low stop bit on tx frame %h", data));
    frame_q.push_back(data);
  endtask

  task automatic send_frame(input logic [DATA_BITS-1:0] data, input reply_mode_e mode);
    logic [10:0] bits;
    bits = {(mode != MODE_BAD_STOP), (^data) ^ (mode == MODE_BAD_PARITY), data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  initial
  begin : device_model
    logic [DATA_BITS-1:0] hi;
    logic [DATA_BITS-1:0] lo;
    @(posedge rst_n);
    forever
    begin
      take_frame(hi);
      if (hi[7] == OP_WRITE)
      begin
        take_frame(lo);
        dev_mem[hi[6:0]] = lo;
      end
      else if (reply_mode != MODE_SILENT)
      begin
        repeat (3 * CLKS_PER_BIT) @(posedge clk);  // Device turnaround.
        send_frame(dev_mem[hi[6:0]], reply_mode);
      end
    end
  end

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------
  initial
  begin : stimulus
    test_row_t   row;
    logic [15:0] word;
    logic        is_write;
    int          start;
    int          waited;
    int          frames_before;
    int          errors_before;
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    reply_mode = MODE_NORMAL;
    seed       = 32'h831b674c;
    for (int i = 0; i < 128; i++)
    begin
      dev_mem[i] = 8'($random(seed));
      exp_mem[i] = dev_mem[i];
    end
    add_row(OP_WRITE, 7'h05, 8'ha5, MODE_NORMAL, 1'b1);
    add_row(OP_READ, 7'h05, 8'h00, MODE_NORMAL, 1'b0);
    add_row(OP_READ, 7'h12, 8'h00, MODE_NORMAL, 1'b0);
    add_row(OP_READ, 7'h12, 8'h00, MODE_BAD_PARITY, 1'b0);
    add_row(OP_WRITE, 7'h7f, 8'h3c, MODE_NORMAL, 1'b0);
    add_row(OP_READ, 7'h7f, 8'h00, MODE_BAD_STOP, 1'b0);
    add_row(OP_READ, 7'h33, 8'h00, MODE_SILENT, 1'b0);
    add_row(OP_READ, 7'h7f, 8'h00, MODE_NORMAL, 1'b0);
    add_row(OP_WRITE, 7'h05, 8'h00, MODE_NORMAL, 1'b1);
    add_row(OP_READ, 7'h05, 8'h00, MODE_NORMAL, 1'b0);
    cycle_limit = rows.size() * ROW_LIMIT;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check(tx === 1'b1 && cmd_rdy === 1'b1 && read_vld === 1'b0,
          $sformatf("after reset tx=%b cmd_rdy=%b read_vld=%b", tx, cmd_rdy, read_vld));

    foreach (rows[n])
    begin
      row           = rows[n];
      word          = row.cmd;
      is_write      = (row.cmd.wr.op == OP_WRITE);
      errors_before = errors;
      frames_before = frames_seen;
      frame_q.delete();
      reply_mode    = row.mode;
      @(posedge clk);
      cmd     <= row.cmd;
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
      @(negedge clk);
      check(!cmd_rdy, "cmd_rdy still high after a command was taken");
      start = cycles;
      if (row.poke)
      begin
        repeat (20) @(posedge clk);
        cmd     <= ~word;                   // Would add a frame if taken.
        cmd_vld <= 1'b1;
        @(posedge clk);
        cmd_vld <= 1'b0;
      end
      waited = 0;
      while (!(is_write ? cmd_rdy : read_vld) && waited < ROW_LIMIT)
      begin
        @(negedge clk);
        waited++;
      end
      if (waited >= ROW_LIMIT)
      begin
        $display("test %0d: no response from the bridge within %0d cycles, state %s",
                 n, ROW_LIMIT, uart_cmd_bridge_i.uart_cmd_fsm_i.state.name());
        errors++;
      end
      else if (is_write)
        check(cycles - start == WRITE_CYCLES,
              $sformatf("write took %0d cycles, expected %0d", cycles - start, WRITE_CYCLES));
      else
      begin
        check(cmd_rdy, "cmd_rdy low in the read_vld cycle");
        check(read_resp.err == row.exp_err,
              $sformatf("read err %b, expected %b", read_resp.err, row.exp_err));
        check(read_resp.data == row.exp_data,
              $sformatf("read data %h, expected %h", read_resp.data, row.exp_data));
      end

      repeat (2 * CLKS_PER_BIT) @(posedge clk);
      @(negedge clk);
      check(tx === 1'b1, "tx not idle after the command");
      check(frames_seen - frames_before == (is_write ? 2 : 1),
            $sformatf("%0d frames on tx", frames_seen - frames_before));
      if (is_write)
      begin
        check(frame_q.size() == 2 && frame_q[0] == word[15:8] && frame_q[1] == word[7:0],
              $sformatf("tx bytes %p, expected %h %h", frame_q, word[15:8], word[7:0]));
        check(dev_mem[word[14:8]] == word[7:0],
              $sformatf("device register %h holds %h", word[14:8], dev_mem[word[14:8]]));
      end
      else
        check(frame_q.size() == 1 && frame_q[0] == word[15:8],
              $sformatf("tx bytes %p, expected %h", frame_q, word[15:8]));

      if (errors != errors_before)
        failed_tests++;
      $display("test %0d %s addr %h reply %s: %s", n, is_write ? "write" : "read",
               word[14:8], reply_mode.name(), (errors == errors_before) ? "ok" : "FAILED");
    end

    $display("%0d tests run, %0d failed, %0d failed checks", rows.size(), failed_tests,
             errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_cmd_bridge.sv
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_bridge
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT      = 434,
  parameter int GAP_BITS          = 16,
  parameter int RESP_TIMEOUT_BITS = 64
) (
  input  wire        clk,
  input  wire        rst_n,
  input  cmd_word_t  cmd,
  input  logic       cmd_vld,
  input  logic       rx,
  output logic       tx,
  output logic       cmd_rdy,
  output logic       read_vld,
  output read_resp_t read_resp
);

  logic                 tx_start;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_done;
  logic                 tx_bit_tick;
  logic                 rx_en;
  logic                 edge_restart;
  logic                 rx_start_seen;
  logic                 rx_done;
  rx_result_t           rx_result;
  logic                 rx_bit_tick;
  logic                 rx_mid_tick;

  uart_cmd_fsm #(
    .GAP_BITS          (GAP_BITS),
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) uart_cmd_fsm_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_done       (tx_done),
    .rx_en         (rx_en),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_result     (rx_result),
    .bit_tick      (rx_bit_tick),
    .read_vld      (read_vld),
    .read_resp     (read_resp)
  );

  uart_baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_baud_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (tx_start),
    .bit_tick (tx_bit_tick),
    .mid_tick ()
  );

  // Realigned by each frame sent, so gap and timeout count whole bits.
  uart_baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_baud_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (edge_restart | tx_start),
    .bit_tick (rx_bit_tick),
    .mid_tick (rx_mid_tick)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .bit_tick (tx_bit_tick),
    .tx       (tx),
    .tx_busy  (),
    .tx_done  (tx_done)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_en         (rx_en),
    .mid_tick      (rx_mid_tick),
    .edge_restart  (edge_restart),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_result     (rx_result)
  );

endmodule

`default_nettype wire

// File: uart_cmd_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module uart_cmd_fsm
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
#(
  parameter int GAP_BITS          = 16,
  parameter int RESP_TIMEOUT_BITS = 64
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  cmd_word_t            cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output logic [DATA_BITS-1:0] tx_byte,
  input  logic                 tx_done,
  output logic                 rx_en,
  input  logic                 rx_start_seen,
  input  logic                 rx_done,
  input  rx_result_t           rx_result,
  input  logic                 bit_tick,
  output logic                 read_vld,
  output read_resp_t           read_resp
);

  localparam int MAX_BITS = (GAP_BITS > RESP_TIMEOUT_BITS) ? GAP_BITS : RESP_TIMEOUT_BITS;
  localparam int CNT_W    = (MAX_BITS > 1) ? $clog2(MAX_BITS) : 1;

  seq_state_e       state;
  cmd_word_t        cmd_q;
  logic [CNT_W-1:0] bit_cnt;
  logic             accept;
  logic             gap_end;
  logic             timeout;

  assign accept  = cmd_vld && cmd_rdy;
  assign gap_end = (state == S_GAP) && bit_tick && (bit_cnt == CNT_W'(GAP_BITS - 1));
  assign timeout = (state == S_WAIT_REPLY) && bit_tick && !rx_start_seen &&
                   (bit_cnt == CNT_W'(RESP_TIMEOUT_BITS - 1));

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      tx_start <= 1'b0;
      bit_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE, S_REPORT:
          if (accept)
          begin
            state    <= S_SEND_HI;
            tx_start <= 1'b1;
          end
          else
            state <= S_IDLE;
        S_SEND_HI:
          if (tx_done)
          begin
            bit_cnt <= '0;
            state   <= (cmd_q.wr.op == OP_WRITE) ? S_GAP : S_WAIT_REPLY;
          end
        S_GAP:
          if (gap_end)
          begin
            state    <= S_SEND_LO;
            tx_start <= 1'b1;
          end
          else if (bit_tick)
            bit_cnt <= bit_cnt + 1'b1;
        S_SEND_LO:
          if (tx_done)
            state <= S_IDLE;
        S_WAIT_REPLY:
          if (rx_start_seen)
            state <= S_RECEIVE;
          else if (timeout)
            state <= S_REPORT;
          else if (bit_tick)
            bit_cnt <= bit_cnt + 1'b1;
        S_RECEIVE:
          if (rx_done)
            state <= S_REPORT;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Command and result holding.
  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
    if (timeout)
    begin
      read_resp.data <= '0;
      read_resp.err  <= 1'b1;
    end
    else if (state == S_RECEIVE && rx_done)
    begin
      read_resp.data <= rx_result.data;
      read_resp.err  <= rx_result.par_err || rx_result.stop_err;
    end
  end

  assign cmd_rdy  = (state == S_IDLE) || (state == S_REPORT);
  assign read_vld = (state == S_REPORT);
  assign rx_en    = (state == S_WAIT_REPLY) || (state == S_RECEIVE);
  assign tx_byte  = (state == S_SEND_LO) ? cmd_q.wr.data : {cmd_q.rd.op, cmd_q.rd.addr};

  a_rdy_after_read : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld && !cmd_vld |=> cmd_rdy
  ) else $error("cmd_rdy low after read_vld");

  a_tx_in_send : assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> (state inside {S_SEND_HI, S_SEND_LO})
  ) else $error("tx_start outside a send state");

endmodule

`default_nettype wire

// File: uart_rx_frame.sv
`default_nettype none
`timescale 1ns/10ps

module uart_rx_frame
  import uart_frame_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  logic       rx,
  input  logic       rx_en,
  input  logic       mid_tick,
  output logic       edge_restart,
  output logic       rx_start_seen,
  output logic       rx_done,
  output rx_result_t rx_result
);

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  frame_phase_t         phase;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_BITS-1:0] shift;
  logic                 par_bit;

  // ----------------------------------------
  // Input synchronizer
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= STOP_BIT;
      rx_sync <= STOP_BIT;
      rx_prev <= STOP_BIT;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;                   // Edge detect stage.
    end
  end

  assign edge_restart  = rx_en && (phase == PH_IDLE) &&
                         (rx_prev == STOP_BIT) && (rx_sync == START_BIT);
  assign rx_start_seen = mid_tick && (phase == PH_START) && (rx_sync == START_BIT);

  // ----------------------------------------
  // Frame walk
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase   <= PH_IDLE;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_en)
        phase <= PH_IDLE;
      else
      begin
        case (phase)
          PH_IDLE:
            if (edge_restart)
              phase <= PH_START;
          PH_START:
            if (mid_tick)
            begin
              bit_idx <= '0;
              phase   <= rx_start_seen ? PH_DATA : PH_IDLE;  // Drop glitches.
            end
          PH_DATA:
            if (mid_tick)
            begin
              if (bit_idx == IDX_W'(DATA_BITS - 1))
                phase <= PH_PARITY;
              else
                bit_idx <= bit_idx + 1'b1;
            end
          PH_PARITY:
            if (mid_tick)
              phase <= PH_STOP;
          default:
            if (mid_tick)
            begin
              phase   <= PH_IDLE;
              rx_done <= 1'b1;
            end
        endcase
      end
    end
  end

  // Sampled data and the verdict.
  always_ff @(posedge clk)
  begin
    if (mid_tick)
    begin
      case (phase)
        PH_DATA:   shift   <= {rx_sync, shift[DATA_BITS-1:1]};
        PH_PARITY: par_bit <= rx_sync;
        PH_STOP:
        begin
          rx_result.data     <= shift;
          rx_result.par_err  <= (even_parity(shift) != par_bit);
          rx_result.stop_err <= (rx_sync != STOP_BIT);
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart_tx_frame.sv
`default_nettype none
`timescale 1ns/10ps

module uart_tx_frame
  import uart_frame_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_byte,
  input  logic                 bit_tick,
  output logic                 tx,
  output logic                 tx_busy,
  output logic                 tx_done
);

  frame_phase_t         phase;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_BITS-1:0] shift;
  logic                 par_bit;

  // ----------------------------------------
  // Frame walk
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase   <= PH_IDLE;
      bit_idx <= '0;
      tx      <= STOP_BIT;
    end
    else
    begin
      case (phase)
        PH_IDLE:
          if (tx_start)
          begin
            phase   <= PH_START;
            bit_idx <= '0;
            tx      <= START_BIT;
          end
        PH_START:
          if (bit_tick)
          begin
            phase <= PH_DATA;
            tx    <= shift[0];               // LSB first.
          end
        PH_DATA:
          if (bit_tick)
          begin
            if (bit_idx == IDX_W'(DATA_BITS - 1))
            begin
              phase <= PH_PARITY;
              tx    <= par_bit;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= shift[0];
            end
          end
        PH_PARITY:
          if (bit_tick)
          begin
            phase <= PH_STOP;
            tx    <= STOP_BIT;
          end
        default:
          if (bit_tick)
            phase <= PH_IDLE;               // Line stays at stop level.
      endcase
    end
  end

  // Payload path.
  always_ff @(posedge clk)
  begin
    if (phase == PH_IDLE && tx_start)
    begin
      shift   <= tx_byte;
      par_bit <= even_parity(tx_byte);
    end
    else if (bit_tick && (phase == PH_START || phase == PH_DATA))
      shift <= shift >> 1;
  end

  assign tx_busy = (phase != PH_IDLE);
  assign tx_done = bit_tick && (phase == PH_STOP);

  a_no_start_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  ) else $error("tx_start while a frame is in flight");

endmodule

`default_nettype wire

// File: uart_baud_gen.sv
`default_nettype none
`timescale 1ns/10ps

module uart_baud_gen #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire  clk,
  input  wire  rst_n,
  input  logic restart,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt <= '0;
    else if (restart)
      cnt <= '0;                            // Realign to a new frame.
    else if (cnt == CNT_W'(CLKS_PER_BIT - 1))
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  assign bit_tick = (cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign mid_tick = (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));

  a_ticks_apart : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(bit_tick && mid_tick)
  ) else $error("bit and mid tick in the same cycle");

endmodule

`default_nettype wire

// File: uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  import uart_frame_pkg::*;

  // ----------------------------------------
  // Command word format
  // ----------------------------------------
  localparam int ADDR_BITS = 7;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e              op;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;             // Goes out as second frame.
  } cmd_wr_t;

  typedef struct packed {
    cmd_op_e              op;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] rsvd;             // Never sent.
  } cmd_rd_t;

  // High byte is common to both views.
  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_REPLY,
    S_RECEIVE,
    S_REPORT
  } seq_state_e;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 err;              // Parity, stop or timeout.
  } read_resp_t;

endpackage

`default_nettype wire

// File: uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

  // ----------------------------------------
  // Line framing
  // ----------------------------------------
  localparam int DATA_BITS = 8;             // Payload bits per frame.
  localparam int IDX_W     = $clog2(DATA_BITS);

  localparam logic START_BIT = 1'b0;        // Also the active edge level.
  localparam logic STOP_BIT  = 1'b1;        // Same as idle line level.

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_START,
    PH_DATA,
    PH_PARITY,
    PH_STOP
  } frame_phase_t;

  // Receiver verdict on one frame.
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 par_err;
    logic                 stop_err;
  } rx_result_t;

  // Even parity bit for one payload byte.
  function automatic logic even_parity(input logic [DATA_BITS-1:0] payload);
    return ^payload;
  endfunction

endpackage

`default_nettype wire
